//--- include/pcie_mm_config.svh
`ifndef PCIE_MM_CONFIG_SVH
`define PCIE_MM_CONFIG_SVH

// request queue entries, also the initial request credits of the sender
`define REQ_DEPTH 4

`define CPL_DEPTH 4         // completion queue entries

// ceiling of the outbound completion credit counter
`define CPL_CREDITS_MAX 8

`define CSR_WORDS 16        // 32-bit registers in the bank

// cycles from read acceptance to readdatavalid
`define CSR_READ_LATENCY 2

`endif

//--- source/pcie_mm_pkg.sv
`default_nettype none

package pcie_mm_pkg;

  // decoded memory request, dword addressing only
  typedef struct packed {
    logic        is_write;
    logic [29:0] dw_addr;
    logic [31:0] wdata;
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic        pad;           // spare bit, descriptor stays at 88 bits
  } mem_req_t;

  // read completion toward the transaction layer
  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic [4:0]  lower_addr;    // byte address bits 6:2
    logic [31:0] data;
  } cpl_t;

  // single-beat Avalon-MM master command
  typedef struct packed {
    logic        read;
    logic        write;
    logic [31:0] address;       // byte address
    logic [31:0] writedata;
  } mm_cmd_t;

  function automatic logic [31:0] dw_to_byte_addr(input logic [29:0] dw_addr);
    return {dw_addr, 2'b00};
  endfunction

  function automatic logic [4:0] lower_addr_of(input logic [29:0] dw_addr);
    return dw_addr[4:0];        // byte bits 6:2
  endfunction

endpackage

`default_nettype wire

//--- source/desc_queue.sv
`default_nettype none

module desc_queue #(
  parameter type payload_t = logic [31:0],
  parameter int  DEPTH     = 4
) (
  input  wire                          clk,
  input  wire                          rst_n,
  input  wire                          push,
  input  wire payload_t                push_data,
  input  wire                          pop,
  output payload_t                     head,
  output logic                         empty,
  output logic                         full,
  output logic [$clog2(DEPTH+1)-1:0]   count
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;

  // wrap explicitly, depth need not be a power of two
  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (pop) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;                          // idle or push and pop together
      endcase
    end
  end

  assign head  = mem[rd_ptr];             // new entry visible one cycle after push
  assign empty = (count == '0);
  assign full  = (count == CNT_W'(DEPTH));

endmodule

`default_nettype wire

//--- source/mm_bridge.sv
`default_nettype none
`include "pcie_mm_config.svh"

module mm_bridge (
  input  wire                              clk,
  input  wire                              rst_n,
  input  wire pcie_mm_pkg::mem_req_t       req_head,
  input  wire                              req_empty,
  output logic                             req_pop,
  output logic                             req_pop_q,
  output logic                             cpl_push,
  output pcie_mm_pkg::cpl_t                cpl_push_data,
  input  wire [$clog2(`CPL_DEPTH+1)-1:0]   cpl_count,
  input  wire                              cpl_empty,
  output logic                             cpl_pop,
  input  wire                              cpl_credit_in,
  output logic                             cpl_valid,
  output pcie_mm_pkg::mm_cmd_t             mm_cmd,
  input  wire                              mm_waitrequest,
  input  wire [31:0]                       mm_readdata,
  input  wire                              mm_readdatavalid
);
  import pcie_mm_pkg::*;

  localparam int CNT_W = $clog2(`CPL_DEPTH + 1);
  localparam int CRD_W = $clog2(`CPL_CREDITS_MAX + 1);

  logic             cmd_read;
  logic             cmd_write;
  logic [31:0]      cmd_addr;
  logic [31:0]      cmd_wdata;
  logic             rd_busy;        // read issued, completion not pushed yet
  logic [15:0]      rd_rid;
  logic [7:0]       rd_tag;
  logic [4:0]       rd_laddr;
  logic [31:0]      rd_data;
  logic [CNT_W:0]   cpl_reserved;
  logic             cpl_space;
  logic             take;
  logic [CRD_W-1:0] cpl_credits;    // completion credits held

  // queue entries plus the read still on its way
  assign cpl_reserved = {1'b0, cpl_count} + {{CNT_W{1'b0}}, rd_busy};
  assign cpl_space    = (cpl_reserved < `CPL_DEPTH);

  // writes only wait for the command slot
  assign take    = !req_empty && !cmd_read && !cmd_write &&
                   (req_head.is_write || (!rd_busy && cpl_space));
  assign req_pop = take;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cmd_read  <= 1'b0;
      cmd_write <= 1'b0;
    end else if (take) begin
      cmd_read  <= !req_head.is_write;
      cmd_write <= req_head.is_write;
    end else if (!mm_waitrequest) begin  // accepted, drop the command
      cmd_read  <= 1'b0;
      cmd_write <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      cmd_addr  <= dw_to_byte_addr(req_head.dw_addr);
      cmd_wdata <= req_head.wdata;
    end
    if (take && !req_head.is_write) begin
      rd_rid   <= req_head.requester_id;
      rd_tag   <= req_head.tag;
      rd_laddr <= lower_addr_of(req_head.dw_addr);
    end
    if (mm_readdatavalid) begin
      rd_data <= mm_readdata;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_busy   <= 1'b0;
      cpl_push  <= 1'b0;
      req_pop_q <= 1'b0;
    end else begin
      req_pop_q <= take;                // one credit back per pop
      cpl_push  <= mm_readdatavalid;
      if (take && !req_head.is_write) begin
        rd_busy <= 1'b1;
      end else if (cpl_push) begin
        rd_busy <= 1'b0;                // now counted by the queue
      end
    end
  end

  assign cpl_valid = !cpl_empty && (cpl_credits != '0);
  assign cpl_pop   = cpl_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      cpl_credits <= '0;
    end else begin
      case ({cpl_credit_in, cpl_pop})
        2'b10: begin
          if (cpl_credits != CRD_W'(`CPL_CREDITS_MAX)) begin
            cpl_credits <= cpl_credits + 1'b1;
          end
        end
        2'b01:   cpl_credits <= cpl_credits - 1'b1;
        default: ;                      // grant and spend cancel out
      endcase
    end
  end

  assign mm_cmd = '{read:      cmd_read,
                    write:     cmd_write,
                    address:   cmd_addr,
                    writedata: cmd_wdata};

  assign cpl_push_data = '{requester_id: rd_rid,
                           tag:          rd_tag,
                           lower_addr:   rd_laddr,
                           data:         rd_data};

endmodule

`default_nettype wire

//--- source/csr_bank.sv
`default_nettype none
`include "pcie_mm_config.svh"

module csr_bank (
  input  wire                       clk,
  input  wire                       rst_n,
  input  wire pcie_mm_pkg::mm_cmd_t mm_cmd,
  output logic                      mm_waitrequest,
  output logic [31:0]               mm_readdata,
  output logic                      mm_readdatavalid
);

  localparam int IDX_W = $clog2(`CSR_WORDS);
  localparam int LAT   = `CSR_READ_LATENCY;

  logic [31:0]      regs [`CSR_WORDS];
  logic             waited;         // first cycle of the command is over
  logic             cmd_active;
  logic             accept;
  logic [IDX_W-1:0] idx;
  logic [LAT-1:0]   rd_vld_sr;
  logic [31:0]      rd_data_sr [LAT];

  assign cmd_active     = mm_cmd.read | mm_cmd.write;
  assign mm_waitrequest = cmd_active & ~waited;
  assign accept         = cmd_active & waited;
  assign idx            = mm_cmd.address[2 +: IDX_W];  // dword index, aliases above the bank

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      waited <= 1'b0;
    end else if (accept) begin
      waited <= 1'b0;
    end else if (cmd_active) begin
      waited <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CSR_WORDS; i++) begin
        regs[i] <= '0;
      end
    end else if (accept && mm_cmd.write) begin
      regs[idx] <= mm_cmd.writedata;
    end
  end

  // valid shifts up from bit 0, top bit is the last stage
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_vld_sr <= '0;
    end else begin
      rd_vld_sr <= LAT'({rd_vld_sr, accept & mm_cmd.read});
    end
  end

  always_ff @(posedge clk) begin
    rd_data_sr[0] <= regs[idx];     // sampled at the acceptance edge
    for (int s = 1; s < LAT; s++) begin
      rd_data_sr[s] <= rd_data_sr[s-1];
    end
  end

  assign mm_readdatavalid = rd_vld_sr[LAT-1];
  assign mm_readdata      = rd_data_sr[LAT-1];

endmodule

`default_nettype wire

//--- source/pcie_mm_top.sv
`default_nettype none
`include "pcie_mm_config.svh"

module pcie_mm_top (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        req_valid,
  input  wire pcie_mm_pkg::mem_req_t req,
  output logic                       req_credit,
  input  wire                        cpl_credit_in,
  output logic                       cpl_valid,
  output pcie_mm_pkg::cpl_t          cpl
);
  import pcie_mm_pkg::*;

  mem_req_t                           req_head;
  logic                               req_empty;
  logic                               req_pop;
  logic                               cpl_push;
  cpl_t                               cpl_push_data;
  logic [$clog2(`CPL_DEPTH+1)-1:0]    cpl_count;
  logic                               cpl_empty;
  logic                               cpl_pop;
  mm_cmd_t                            mm_cmd;
  logic                               mm_waitrequest;
  logic [31:0]                        mm_readdata;
  logic                               mm_readdatavalid;

  // sender credits guard against overflow here
  desc_queue #(.payload_t(mem_req_t), .DEPTH(`REQ_DEPTH)) u_req_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (req_valid),
    .push_data (req),
    .pop       (req_pop),
    .head      (req_head),
    .empty     (req_empty),
    .full      (),
    .count     ()
  );

  desc_queue #(.payload_t(cpl_t), .DEPTH(`CPL_DEPTH)) u_cpl_q (
    .clk       (clk),
    .rst_n     (rst_n),
    .push      (cpl_push),
    .push_data (cpl_push_data),
    .pop       (cpl_pop),
    .head      (cpl),                   // head drives the completion output
    .empty     (cpl_empty),
    .full      (),
    .count     (cpl_count)
  );

  mm_bridge u_bridge (
    .clk              (clk),
    .rst_n            (rst_n),
    .req_head         (req_head),
    .req_empty        (req_empty),
    .req_pop          (req_pop),
    .req_pop_q        (req_credit),
    .cpl_push         (cpl_push),
    .cpl_push_data    (cpl_push_data),
    .cpl_count        (cpl_count),
    .cpl_empty        (cpl_empty),
    .cpl_pop          (cpl_pop),
    .cpl_credit_in    (cpl_credit_in),
    .cpl_valid        (cpl_valid),
    .mm_cmd           (mm_cmd),
    .mm_waitrequest   (mm_waitrequest),
    .mm_readdata      (mm_readdata),
    .mm_readdatavalid (mm_readdatavalid)
  );

  csr_bank u_csr (
    .clk              (clk),
    .rst_n            (rst_n),
    .mm_cmd           (mm_cmd),
    .mm_waitrequest   (mm_waitrequest),
    .mm_readdata      (mm_readdata),
    .mm_readdatavalid (mm_readdatavalid)
  );

endmodule

`default_nettype wire

//--- bench/tb_pcie_mm_asserts.sv
`default_nettype none
`include "pcie_mm_config.svh"

module tb_pcie_mm_asserts (
  input wire                                  clk,
  input wire                                  rst_n,
  input wire pcie_mm_pkg::mm_cmd_t            mm_cmd,
  input wire                                  mm_waitrequest,
  input wire                                  cpl_push,
  input wire [$clog2(`CPL_DEPTH+1)-1:0]       cpl_count,
  input wire                                  cpl_credit_in,
  input wire                                  cpl_valid,
  input wire [$clog2(`CPL_CREDITS_MAX+1)-1:0] cpl_credits
);

  a_cmd_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(mm_cmd.read && mm_cmd.write))
    else $error("avalon read and write high in the same cycle");

  // slave has not taken it yet so nothing may move
  a_cmd_stable: assert property (@(posedge clk) disable iff (!rst_n)
    (mm_cmd.read || mm_cmd.write) && mm_waitrequest |=> $stable(mm_cmd))
    else $error("avalon command changed while waitrequest was high");

  a_cpl_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
    cpl_push |-> cpl_count < `CPL_DEPTH)
    else $error("completion queue pushed while full");

  // no credit held and none granted means no completion next cycle
  a_cpl_credit: assert property (@(posedge clk) disable iff (!rst_n)
    cpl_credits == '0 && !cpl_credit_in |=> !cpl_valid)
    else $error("cpl_valid raised with no completion credit held");

endmodule

`default_nettype wire

//--- bench/tb_pcie_mm.sv
`default_nettype none
`include "pcie_mm_config.svh"

module tb_pcie_mm;
  import pcie_mm_pkg::*;

  localparam int TEST_REQS   = 3 * `CSR_WORDS + 200 + `CPL_DEPTH + 2;
  localparam int TIMEOUT     = TEST_REQS * 40;
  localparam int DRAIN_LIMIT = (`REQ_DEPTH + `CPL_DEPTH + 2) * 40;
  localparam int IDX_W       = $clog2(`CSR_WORDS);

  logic        clk = 1'b0;
  logic        rst_n;
  logic        req_valid;
  mem_req_t    req;
  logic        req_credit;
  logic        cpl_credit_in;
  logic        cpl_valid;
  cpl_t        cpl;
  integer      seed = 32'h59f0_4f1d;
  logic [31:0] model [`CSR_WORDS];
  cpl_t        exp_mem [256];           // ring of expected completions
  int          exp_wr = 0;
  int          exp_rd = 0;
  int          reqs_sent = 0;
  int          credits_returned = 0;
  int          credits_granted = 0;
  int          cpls_seen = 0;
  int          credit_mode = 0;         // 0 withheld, 1 frequent, 2 sparse
  int          cycles = 0;
  int          main_errors = 0;
  int          mon_errors = 0;
  int          passed = 0;
  int          failed = 0;
  int          mark;
  logic [7:0]  next_tag = 8'd0;

  always #5 clk = ~clk;

  pcie_mm_top DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .req_valid     (req_valid),
    .req           (req),
    .req_credit    (req_credit),
    .cpl_credit_in (cpl_credit_in),
    .cpl_valid     (cpl_valid),
    .cpl           (cpl)
  );

  bind mm_bridge tb_pcie_mm_asserts u_asserts (
    .clk            (clk),
    .rst_n          (rst_n),
    .mm_cmd         (mm_cmd),
    .mm_waitrequest (mm_waitrequest),
    .cpl_push       (cpl_push),
    .cpl_count      (cpl_count),
    .cpl_credit_in  (cpl_credit_in),
    .cpl_valid      (cpl_valid),
    .cpl_credits    (cpl_credits)
  );

  // one clock; credits go out only for reads still owed a completion
  task automatic tick;
    @(posedge clk);
    #1;
    cpl_credit_in = 1'b0;
    if (credit_mode != 0 && credits_granted - cpls_seen < exp_wr - exp_rd) begin
      cpl_credit_in = ($random(seed) & (credit_mode == 1 ? 1 : 7)) == 0;
    end
  endtask

  task automatic send_req(input logic wr, input logic [29:0] dw_addr,
                          input logic [31:0] data);
    logic [IDX_W-1:0] idx;
    logic [15:0]      rid;
    idx = IDX_W'(dw_addr % `CSR_WORDS);  // upper addresses alias into the bank
    rid = 16'($random(seed));
    while (`REQ_DEPTH + credits_returned - reqs_sent <= 0) begin
      tick();                            // out of request credits
    end
    req_valid = 1'b1;
    req = '{is_write: wr, dw_addr: dw_addr, wdata: data, requester_id: rid,
            tag: next_tag, pad: 1'b0};
    reqs_sent++;
    if (wr) begin
      model[idx] = data;
    end else begin
      exp_mem[exp_wr[7:0]] = '{requester_id: rid, tag: next_tag,
                               lower_addr: dw_addr[4:0], data: model[idx]};
      exp_wr++;
    end
    next_tag = next_tag + 8'd1;
    tick();
    req_valid = 1'b0;
  endtask

  task automatic drain;
    int waited;
    waited = 0;
    while ((exp_rd != exp_wr || credits_returned != reqs_sent) &&
           waited < DRAIN_LIMIT) begin
      tick();
      waited++;
    end
    repeat (4) tick();
  endtask

  task automatic check_counts;
    assert (credits_returned == reqs_sent) else begin
      $display("Fail time %0t req_credit count got %0d expected %0d",
               $time, credits_returned, reqs_sent);
      main_errors++;
    end
    assert (cpls_seen == exp_wr) else begin
      $display("Fail time %0t cpl_valid count got %0d expected %0d",
               $time, cpls_seen, exp_wr);
      main_errors++;
    end
  endtask

  task automatic report_test(input string name);
    if (main_errors + mon_errors == mark) begin
      passed++;
      $display("%s: passed", name);
    end else begin
      failed++;
      $display("%s: failed, %0d errors", name, main_errors + mon_errors - mark);
    end
    mark = main_errors + mon_errors;
  endtask

  // outputs sampled mid-cycle away from the driving edge
  always @(negedge clk) begin
    if (rst_n) begin
      if (req_credit) begin
        assert (credits_returned < reqs_sent) else begin
          $display("req_credit at %0t returned more credits than requests sent", $time);
          mon_errors++;
        end
        credits_returned++;
      end
      if (cpl_valid) begin
        assert (cpls_seen < credits_granted && exp_rd < exp_wr) else begin
          $display("cpl_valid at %0t without a granted credit or an open read", $time);
          mon_errors++;
        end
        assert (cpl == exp_mem[exp_rd[7:0]]) else begin
          $display("Fail time %0t cpl got %h expected %h", $time, cpl,
                   exp_mem[exp_rd[7:0]]);
          mon_errors++;
        end
        exp_rd++;
        cpls_seen++;
      end
      if (cpl_credit_in) begin
        credits_granted++;               // usable from the next cycle
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > TIMEOUT) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT);
      $display("TEST FAILED");
      $finish;
    end
  end

  initial begin
    rst_n         = 1'b0;
    req_valid     = 1'b0;
    req           = '0;
    cpl_credit_in = 1'b0;
    mark          = 0;
    model         = '{default: '0};
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;

    repeat (10) begin                    // idle so nothing may come out
      tick();
      assert (!req_credit && !cpl_valid) else begin
        $display("Fail time %0t req_credit,cpl_valid got %b%b expected 00",
                 $time, req_credit, cpl_valid);
        main_errors++;
      end
    end
    credit_mode = 1;
    for (int i = 0; i < `CSR_WORDS; i++) begin
      send_req(1'b0, 30'(i), '0);
    end
    drain();
    report_test("reset state and zero readback");

    for (int i = 0; i < `CSR_WORDS; i++) begin
      send_req(1'b1, 30'(i), {8'h5a, 8'(i), ~16'(i)});
    end
    for (int i = 0; i < `CSR_WORDS; i++) begin
      send_req(1'b0, 30'(i), '0);
    end
    drain();
    report_test("pattern write and readback");

    for (int n = 0; n < 200; n++) begin
      send_req(1'($random(seed)), 30'($random(seed)), $random(seed));
      repeat ($random(seed) & 3) tick();
    end
    drain();
    report_test("random writes and reads");

    check_counts();
    report_test("credit accounting");

    credit_mode = 0;                     // completions pile up in the queue
    for (int n = 0; n < `CPL_DEPTH + 2; n++) begin
      send_req(1'b0, 30'($random(seed)), '0);
    end
    repeat (40) tick();
    assert (exp_wr - exp_rd == `CPL_DEPTH + 2) else begin
      $display("Fail time %0t cpl_valid count got %0d expected 0",
               $time, `CPL_DEPTH + 2 - (exp_wr - exp_rd));
      main_errors++;
    end
    credit_mode = 2;
    drain();
    check_counts();
    report_test("completion back-pressure");

    $display("tests passed %0d, failed %0d", passed, failed);
    if (failed == 0 && main_errors + mon_errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+include
source/pcie_mm_pkg.sv
source/desc_queue.sv
source/mm_bridge.sv
source/csr_bank.sv
source/pcie_mm_top.sv
bench/tb_pcie_mm_asserts.sv
bench/tb_pcie_mm.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_pcie_mm \
  -Mdir obj_dir -o tb_pcie_mm > build.log 2>&1 \
  && ./obj_dir/tb_pcie_mm > sim.log 2>&1 \
  || { cat build.log; echo "build or simulation exited with an error" >> sim.log; \
       echo "TEST FAILED" >> sim.log; }

cat sim.log
grep -q "TEST FAILED" sim.log && exit 1 || exit 0
